// ==== source/lc3b_defs.svh ====
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// data and address width
`define LC3B_WORD_W 16

// architectural registers r0..r7
`define LC3B_NUM_REGS 8

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

`endif

// ==== source/lc3b_pkg.sv ====
`default_nettype none

`include "lc3b_defs.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;               // n, z, p
    typedef logic [1:0] lc3b_mem_wmask;         // one bit per byte lane

    typedef enum logic [3:0] {
        op_br,  op_add, op_ldb, op_stb,
        op_jsr, op_and, op_ldr, op_str,
        op_rti, op_not, op_ldi, op_sti,
        op_jmp, op_shf, op_lea, op_trap
    } lc3b_opcode;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} alu_op_t;

    // operand b of the alu
    typedef enum logic [1:0] {alumux_reg, alumux_imm, alumux_addr} alumux_sel_t;

    // source of a forwarded execute operand
    typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_t;

    typedef struct packed {
        lc3b_opcode  opcode;
        alu_op_t     aluop;
        alumux_sel_t alumux_sel;
        logic        load_regfile;
        logic        regfilemux_sel;    // 1 = load data from memory
        logic        mem_read;
        logic        mem_write;
        logic        is_byte;
        logic        load_cc;
        logic        is_branch;
        logic        is_jump;
        logic        is_nop;
        logic        uses_a;            // reads ir[8:6]
        logic        uses_b;            // reads ir[2:0] or store source
        logic        storemux_sel;      // b index from ir[11:9]
    } lc3b_control_word;

    // control word of an empty slot
    function automatic lc3b_control_word nop_ctrl();
        lc3b_control_word c;
        c = '0;
        c.is_nop = 1'b1;
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== source/fwd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fwd_if;
    lc3b_pkg::lc3b_reg id_sr_a;
    lc3b_pkg::lc3b_reg id_sr_b;
    logic              id_uses_a;
    logic              id_uses_b;
    lc3b_pkg::lc3b_reg ex_sr_a;
    lc3b_pkg::lc3b_reg ex_sr_b;
    lc3b_pkg::lc3b_reg ex_dest;
    logic              ex_mem_read;       // load sitting in execute
    lc3b_pkg::lc3b_reg mem_dest;
    logic              mem_load;          // memory stage writes a register
    lc3b_pkg::lc3b_reg wb_dest;
    logic              wb_load;
    lc3b_pkg::fwd_sel_t sel_a;
    lc3b_pkg::fwd_sel_t sel_b;
    logic              bubble;

    modport datapath (
        output id_sr_a, id_sr_b, id_uses_a, id_uses_b, ex_sr_a, ex_sr_b, ex_dest,
        output ex_mem_read, mem_dest, mem_load, wb_dest, wb_load,
        input  sel_a, sel_b, bubble
    );

    modport hazard (
        input  id_sr_a, id_sr_b, id_uses_a, id_uses_b, ex_sr_a, ex_sr_b, ex_dest,
        input  ex_mem_read, mem_dest, mem_load, wb_dest, wb_load,
        output sel_a, sel_b, bubble
    );
endinterface

`default_nettype wire

// ==== source/control_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_rom
(
    input  wire lc3b_pkg::lc3b_word   instr,
    output lc3b_pkg::lc3b_control_word ctrl
);

    lc3b_pkg::lc3b_opcode opcode;

    assign opcode = lc3b_pkg::lc3b_opcode'(instr[15:12]);

    always_comb
    begin
        ctrl = lc3b_pkg::nop_ctrl();
        ctrl.opcode = opcode;
        if (instr != '0)                    // all-zero word stays a nop
        begin
            unique case (opcode)
                lc3b_pkg::op_add, lc3b_pkg::op_and:
                begin
                    ctrl.is_nop = 1'b0;
                    ctrl.aluop = (opcode == lc3b_pkg::op_add) ? lc3b_pkg::alu_add
                                                              : lc3b_pkg::alu_and;
                    ctrl.alumux_sel = instr[5] ? lc3b_pkg::alumux_imm : lc3b_pkg::alumux_reg;
                    ctrl.uses_a = 1'b1;
                    ctrl.uses_b = ~instr[5];    // imm5 form has no sr2
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc = 1'b1;
                end
                lc3b_pkg::op_not:
                begin
                    ctrl.is_nop = 1'b0;
                    ctrl.aluop = lc3b_pkg::alu_not;
                    ctrl.uses_a = 1'b1;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc = 1'b1;
                end
                lc3b_pkg::op_lea:
                begin
                    ctrl.is_nop = 1'b0;
                    ctrl.aluop = lc3b_pkg::alu_pass;
                    ctrl.alumux_sel = lc3b_pkg::alumux_addr;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc = 1'b1;
                end
                lc3b_pkg::op_ldr:
                begin
                    ctrl.is_nop = 1'b0;
                    ctrl.uses_a = 1'b1;
                    ctrl.mem_read = 1'b1;
                    ctrl.regfilemux_sel = 1'b1;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc = 1'b1;
                end
                lc3b_pkg::op_str, lc3b_pkg::op_stb:
                begin
                    ctrl.is_nop = 1'b0;
                    ctrl.uses_a = 1'b1;
                    ctrl.uses_b = 1'b1;
                    ctrl.storemux_sel = 1'b1;   // store source in ir[11:9]
                    ctrl.mem_write = 1'b1;
                    ctrl.is_byte = (opcode == lc3b_pkg::op_stb);
                end
                lc3b_pkg::op_br:
                begin
                    ctrl.is_nop = 1'b0;
                    ctrl.is_branch = 1'b1;
                end
                lc3b_pkg::op_jmp:
                begin
                    ctrl.is_nop = 1'b0;
                    ctrl.is_jump = 1'b1;
                    ctrl.uses_a = 1'b1;
                end
                default: ;                      // unsupported opcodes stay nops
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defs.svh"

module regfile
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               wr_en,
    input  wire lc3b_pkg::lc3b_reg  wr_reg,
    input  wire lc3b_pkg::lc3b_reg  rd_a,
    input  wire lc3b_pkg::lc3b_reg  rd_b,
    input  wire lc3b_pkg::lc3b_word wr_data,
    output lc3b_pkg::lc3b_word      reg_a,
    output lc3b_pkg::lc3b_word      reg_b
);

    lc3b_pkg::lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_reg] <= wr_data;
    end

    // write-through so decode sees the value retiring this cycle
    assign reg_a = (wr_en && wr_reg == rd_a) ? wr_data : regs[rd_a];
    assign reg_b = (wr_en && wr_reg == rd_b) ? wr_data : regs[rd_b];

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
(
    fwd_if.hazard fwd
);

    // memory stage is younger, so it wins over writeback
    function automatic lc3b_pkg::fwd_sel_t pick_source
    (
        input lc3b_pkg::lc3b_reg src,
        input logic              mem_load,
        input lc3b_pkg::lc3b_reg mem_dest,
        input logic              wb_load,
        input lc3b_pkg::lc3b_reg wb_dest
    );
        lc3b_pkg::fwd_sel_t sel;
        if (mem_load && mem_dest == src)
            sel = lc3b_pkg::fwd_mem;
        else if (wb_load && wb_dest == src)
            sel = lc3b_pkg::fwd_wb;
        else
            sel = lc3b_pkg::fwd_reg;
        return sel;
    endfunction

    logic hit_a;
    logic hit_b;

    always_comb
    begin
        fwd.sel_a = pick_source(fwd.ex_sr_a, fwd.mem_load, fwd.mem_dest,
                                fwd.wb_load, fwd.wb_dest);
        fwd.sel_b = pick_source(fwd.ex_sr_b, fwd.mem_load, fwd.mem_dest,
                                fwd.wb_load, fwd.wb_dest);
    end

    // load data is not ready until the memory stage completes
    assign hit_a = fwd.id_uses_a && (fwd.id_sr_a == fwd.ex_dest);
    assign hit_b = fwd.id_uses_b && (fwd.id_sr_b == fwd.ex_dest);
    assign fwd.bubble = fwd.ex_mem_read && (hit_a || hit_b);

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defs.svh"

module datapath
(
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       i_mem_resp,
    input  wire logic                       d_mem_resp,
    input  wire lc3b_pkg::lc3b_word         instr_rdata,
    input  wire lc3b_pkg::lc3b_word         mem_rdata,
    output logic                            instr_read,
    output logic                            mem_read,
    output logic                            mem_write,
    output lc3b_pkg::lc3b_word              instr_address,
    output lc3b_pkg::lc3b_word              mem_address,
    output lc3b_pkg::lc3b_word              mem_wdata,
    output lc3b_pkg::lc3b_mem_wmask         mem_byte_enable,
    output lc3b_pkg::lc3b_word              dec_instr,
    input  wire lc3b_pkg::lc3b_control_word dec_ctrl,
    output lc3b_pkg::lc3b_reg               rd_a,
    output lc3b_pkg::lc3b_reg               rd_b,
    input  wire lc3b_pkg::lc3b_word         reg_a,
    input  wire lc3b_pkg::lc3b_word         reg_b,
    output logic                            wr_en,
    output lc3b_pkg::lc3b_reg               wr_reg,
    output lc3b_pkg::lc3b_word              wr_data,
    fwd_if.datapath                         fwd
);

    logic advance;
    logic load_fetch;
    logic take_branch;
    logic flush;

    lc3b_pkg::lc3b_word pc;
    lc3b_pkg::lc3b_word pc_plus2;
    lc3b_pkg::lc3b_word id_instr;
    lc3b_pkg::lc3b_word id_pc;

    lc3b_pkg::lc3b_control_word ex_ctrl;
    lc3b_pkg::lc3b_word ex_instr;
    lc3b_pkg::lc3b_word ex_pc;
    lc3b_pkg::lc3b_word ex_a;
    lc3b_pkg::lc3b_word ex_b;
    lc3b_pkg::lc3b_word fwd_a;
    lc3b_pkg::lc3b_word fwd_b;
    lc3b_pkg::lc3b_word alu_b;
    lc3b_pkg::lc3b_word alu_out;
    lc3b_pkg::lc3b_word addr;

    lc3b_pkg::lc3b_control_word mem_ctrl;
    lc3b_pkg::lc3b_word mem_result;
    lc3b_pkg::lc3b_word mem_addr;
    lc3b_pkg::lc3b_word mem_store;
    lc3b_pkg::lc3b_word mem_data;
    lc3b_pkg::lc3b_reg  mem_dest;       // also the nzp field of a BR

    lc3b_pkg::lc3b_control_word wb_ctrl;
    lc3b_pkg::lc3b_word wb_result;
    lc3b_pkg::lc3b_reg  wb_dest;
    lc3b_pkg::lc3b_nzp  wb_cc;
    lc3b_pkg::lc3b_nzp  cc;
    lc3b_pkg::lc3b_nzp  branch_cc;

    // stall everything on any outstanding response
    assign advance = instr_read && i_mem_resp
                     && (d_mem_resp || !(mem_ctrl.mem_read || mem_ctrl.mem_write));
    assign load_fetch = advance && (flush || !fwd.bubble);

    assign pc_plus2 = pc + 16'd2;
    assign instr_address = pc;

    // decode
    assign dec_instr = id_instr;
    assign rd_a = id_instr[8:6];
    assign rd_b = dec_ctrl.storemux_sel ? id_instr[11:9] : id_instr[2:0];

    assign fwd.id_sr_a = rd_a;
    assign fwd.id_sr_b = rd_b;
    assign fwd.id_uses_a = dec_ctrl.uses_a;
    assign fwd.id_uses_b = dec_ctrl.uses_b;
    assign fwd.ex_sr_a = ex_instr[8:6];
    assign fwd.ex_sr_b = ex_ctrl.storemux_sel ? ex_instr[11:9] : ex_instr[2:0];
    assign fwd.ex_dest = ex_instr[11:9];
    assign fwd.ex_mem_read = ex_ctrl.mem_read;
    assign fwd.mem_dest = mem_dest;
    assign fwd.mem_load = mem_ctrl.load_regfile;
    assign fwd.wb_dest = wb_dest;
    assign fwd.wb_load = wb_ctrl.load_regfile;

    // execute
    always_comb
    begin
        case (fwd.sel_a)
            lc3b_pkg::fwd_mem: fwd_a = mem_data;
            lc3b_pkg::fwd_wb:  fwd_a = wb_result;
            default:           fwd_a = ex_a;
        endcase
        case (fwd.sel_b)
            lc3b_pkg::fwd_mem: fwd_b = mem_data;
            lc3b_pkg::fwd_wb:  fwd_b = wb_result;
            default:           fwd_b = ex_b;
        endcase

        if (ex_ctrl.is_branch || ex_ctrl.opcode == lc3b_pkg::op_lea)
            addr = ex_pc + {{6{ex_instr[8]}}, ex_instr[8:0], 1'b0};
        else if (ex_ctrl.is_byte)
            addr = fwd_a + {{10{ex_instr[5]}}, ex_instr[5:0]};   // unscaled byte offset
        else
            addr = fwd_a + {{9{ex_instr[5]}}, ex_instr[5:0], 1'b0};

        case (ex_ctrl.alumux_sel)
            lc3b_pkg::alumux_imm:  alu_b = {{11{ex_instr[4]}}, ex_instr[4:0]};
            lc3b_pkg::alumux_addr: alu_b = addr;
            default:               alu_b = fwd_b;
        endcase

        case (ex_ctrl.aluop)
            lc3b_pkg::alu_add: alu_out = fwd_a + alu_b;
            lc3b_pkg::alu_and: alu_out = fwd_a & alu_b;
            lc3b_pkg::alu_not: alu_out = ~fwd_a;
            default:           alu_out = alu_b;
        endcase
    end

    // memory
    assign mem_data = mem_ctrl.regfilemux_sel ? mem_rdata : mem_result;
    assign mem_read = mem_ctrl.mem_read;
    assign mem_write = mem_ctrl.mem_write;
    assign mem_address = mem_addr;
    assign mem_wdata = mem_ctrl.is_byte ? {2{mem_store[7:0]}} : mem_store;
    assign mem_byte_enable = !mem_ctrl.is_byte ? 2'b11 : (mem_addr[0] ? 2'b10 : 2'b01);

    // the older instruction's flags are still in writeback
    assign wb_cc = wb_result[15] ? 3'b100 : ((wb_result == '0) ? 3'b010 : 3'b001);
    assign branch_cc = wb_ctrl.load_regfile ? wb_cc : cc;
    assign take_branch = mem_ctrl.is_branch && |(mem_dest & branch_cc);
    assign flush = take_branch || mem_ctrl.is_jump;

    // writeback
    assign wr_en = advance && wb_ctrl.load_regfile;
    assign wr_reg = wb_dest;
    assign wr_data = wb_result;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            instr_read <= 1'b0;
            pc <= `LC3B_RESET_PC;
            id_instr <= '0;
            ex_ctrl <= lc3b_pkg::nop_ctrl();
            mem_ctrl <= lc3b_pkg::nop_ctrl();
            wb_ctrl <= lc3b_pkg::nop_ctrl();
            cc <= 3'b010;
        end
        else
        begin
            instr_read <= 1'b1;
            if (load_fetch)
            begin
                pc <= flush ? mem_addr : pc_plus2;
                id_instr <= flush ? '0 : instr_rdata;
            end
            if (advance)
            begin
                ex_ctrl <= (flush || fwd.bubble) ? lc3b_pkg::nop_ctrl() : dec_ctrl;
                mem_ctrl <= flush ? lc3b_pkg::nop_ctrl() : ex_ctrl;
                wb_ctrl <= mem_ctrl;
                if (wb_ctrl.load_cc)
                    cc <= wb_cc;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_fetch)
            id_pc <= pc_plus2;
        if (advance)
        begin
            ex_instr <= id_instr;
            ex_pc <= id_pc;
            ex_a <= reg_a;
            ex_b <= reg_b;
            mem_result <= alu_out;
            mem_addr <= addr;
            mem_store <= fwd_b;             // store source after forwarding
            mem_dest <= ex_instr[11:9];
            wb_result <= mem_data;
            wb_dest <= mem_dest;
        end
    end

endmodule

`default_nettype wire

// ==== source/lc3b_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               i_mem_resp,
    input  wire logic               d_mem_resp,
    input  wire lc3b_pkg::lc3b_word instr_rdata,
    input  wire lc3b_pkg::lc3b_word mem_rdata,
    output logic                    instr_read,
    output logic                    mem_read,
    output logic                    mem_write,
    output lc3b_pkg::lc3b_word      instr_address,
    output lc3b_pkg::lc3b_word      mem_address,
    output lc3b_pkg::lc3b_word      mem_wdata,
    output lc3b_pkg::lc3b_mem_wmask mem_byte_enable
);

    lc3b_pkg::lc3b_word         dec_instr;
    lc3b_pkg::lc3b_control_word dec_ctrl;
    lc3b_pkg::lc3b_reg          rd_a;
    lc3b_pkg::lc3b_reg          rd_b;
    lc3b_pkg::lc3b_word         reg_a;
    lc3b_pkg::lc3b_word         reg_b;
    logic                       wr_en;
    lc3b_pkg::lc3b_reg          wr_reg;
    lc3b_pkg::lc3b_word         wr_data;

    fwd_if fwd ();

    datapath i_datapath
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_mem_resp      (i_mem_resp),
        .d_mem_resp      (d_mem_resp),
        .instr_rdata     (instr_rdata),
        .mem_rdata       (mem_rdata),
        .instr_read      (instr_read),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .instr_address   (instr_address),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .dec_instr       (dec_instr),
        .dec_ctrl        (dec_ctrl),
        .rd_a            (rd_a),
        .rd_b            (rd_b),
        .reg_a           (reg_a),
        .reg_b           (reg_b),
        .wr_en           (wr_en),
        .wr_reg          (wr_reg),
        .wr_data         (wr_data),
        .fwd             (fwd.datapath)
    );

    control_rom i_control_rom
    (
        .instr (dec_instr),
        .ctrl  (dec_ctrl)
    );

    regfile i_regfile
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_reg  (wr_reg),
        .rd_a    (rd_a),
        .rd_b    (rd_b),
        .wr_data (wr_data),
        .reg_a   (reg_a),
        .reg_b   (reg_b)
    );

    hazard_unit i_hazard_unit
    (
        .fwd (fwd.hazard)
    );

endmodule

`default_nettype wire

// ==== test/lc3b_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu_tb;

    localparam int PROG_WORDS = 64;
    localparam int EXP_BASE = 'h40;         // count word, then one triple per write
    localparam int MAX_DELAY = 3;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 40;

    logic                    clk;
    logic                    rst_n;
    logic                    i_mem_resp;
    logic                    d_mem_resp;
    lc3b_pkg::lc3b_word      instr_rdata;
    lc3b_pkg::lc3b_word      mem_rdata;
    logic                    instr_read;
    logic                    mem_read;
    logic                    mem_write;
    lc3b_pkg::lc3b_word      instr_address;
    lc3b_pkg::lc3b_word      mem_address;
    lc3b_pkg::lc3b_word      mem_wdata;
    lc3b_pkg::lc3b_mem_wmask mem_byte_enable;

    lc3b_pkg::lc3b_word patterns [0:127];
    lc3b_pkg::lc3b_word dmem [0:32767];

    integer             seed;
    int                 cycle;
    int                 exp_count;
    int                 writes_seen;
    int                 errors;
    int                 tests_passed;
    int                 tests_failed;
    int                 level_errors;
    int                 i_delay;
    int                 d_delay;
    bit                 i_fresh;
    bit                 d_fresh;
    bit                 d_recorded;
    bit                 d_pending;
    bit                 loaded;
    lc3b_pkg::lc3b_word pend_addr;
    logic               pend_write;

    lc3b_cpu i_dut
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_mem_resp      (i_mem_resp),
        .d_mem_resp      (d_mem_resp),
        .instr_rdata     (instr_rdata),
        .mem_rdata       (mem_rdata),
        .instr_read      (instr_read),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .instr_address   (instr_address),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable)
    );

    always #2 clk = ~clk;

    function automatic int pick_delay();
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % (MAX_DELAY + 1);
    endfunction

    function automatic lc3b_pkg::lc3b_word fetch_word(input lc3b_pkg::lc3b_word addr);
        lc3b_pkg::lc3b_word w;
        w = 16'h0000;                       // past the program reads as nop
        if (addr[15:1] < PROG_WORDS)
            w = patterns[addr[15:1]];
        return w;
    endfunction

    task automatic store_to_dmem(input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word data,
                                 input lc3b_pkg::lc3b_mem_wmask be);
        if (be[0])
            dmem[addr[15:1]][7:0] = data[7:0];
        if (be[1])
            dmem[addr[15:1]][15:8] = data[15:8];
    endtask

    task automatic check_reset_state();
        int bad;
        bad = 0;
        assert (mem_read == 1'b0) else
        begin
            $display("MISMATCH mem_read after reset: got %h expected %h", mem_read, 1'b0);
            bad++;
        end
        assert (mem_write == 1'b0) else
        begin
            $display("MISMATCH mem_write after reset: got %h expected %h", mem_write, 1'b0);
            bad++;
        end
        assert (instr_address == 16'h0000) else
        begin
            $display("MISMATCH instr_address after reset: got %h expected %h",
                     instr_address, 16'h0000);
            bad++;
        end
        errors += bad;
        if (bad == 0)
        begin
            tests_passed++;
            $display("reset state: ok");
        end
        else
        begin
            tests_failed++;
            $display("reset state: failed");
        end
    endtask

    task automatic check_write(input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word data,
                               input lc3b_pkg::lc3b_mem_wmask be);
        int                      base;
        int                      bad;
        lc3b_pkg::lc3b_word      exp_addr;
        lc3b_pkg::lc3b_word      exp_data;
        lc3b_pkg::lc3b_mem_wmask exp_be;
        bad = 0;
        if (writes_seen >= exp_count)
        begin
            $display("unexpected write of %h to address %h after the last expected write",
                     data, addr);
            errors++;
            tests_failed++;
        end
        else
        begin
            base = EXP_BASE + 1 + 3 * writes_seen;
            exp_addr = patterns[base];
            exp_data = patterns[base + 1];
            exp_be = patterns[base + 2][1:0];
            assert (addr == exp_addr) else
            begin
                $display("MISMATCH mem_address write %0d: got %h expected %h",
                         writes_seen, addr, exp_addr);
                bad++;
            end
            assert (data == exp_data) else
            begin
                $display("MISMATCH mem_wdata write %0d: got %h expected %h",
                         writes_seen, data, exp_data);
                bad++;
            end
            assert (be == exp_be) else
            begin
                $display("MISMATCH mem_byte_enable write %0d: got %h expected %h",
                         writes_seen, be, exp_be);
                bad++;
            end
            errors += bad;
            if (bad == 0)
            begin
                tests_passed++;
                $display("write %0d: ok, %h <- %h enable %b", writes_seen, addr, data, be);
            end
            else
            begin
                tests_failed++;
                $display("write %0d: failed", writes_seen);
            end
            writes_seen++;
        end
    endtask

    // instruction and data memory models
    always @(negedge clk)
    begin : drive
        logic access;
        logic adv;
        cycle = cycle + 1;
        access = mem_read || mem_write;
        if (cycle == RESET_CYCLES)
        begin
            check_reset_state();
            rst_n = 1'b1;
        end
        else if (cycle > RESET_CYCLES && instr_read)
        begin
            if (d_pending)
            begin
                assert (access && mem_address == pend_addr && mem_write == pend_write) else
                begin
                    $display("data request at %h dropped or changed before its response",
                             pend_addr);
                    level_errors++;
                end
            end
            if (i_fresh)
            begin
                i_delay = pick_delay();
                i_fresh = 1'b0;
            end
            i_mem_resp = (i_delay == 0);
            if (i_delay != 0)
                i_delay--;
            instr_rdata = fetch_word(instr_address);

            d_mem_resp = 1'b0;
            if (access)
            begin
                if (d_fresh)
                begin
                    d_delay = pick_delay();
                    d_fresh = 1'b0;
                end
                d_mem_resp = (d_delay == 0);
                if (d_delay != 0)
                    d_delay--;
            end
            if (d_mem_resp && mem_read)
                mem_rdata = dmem[mem_address[15:1]];
            if (d_mem_resp && mem_write && !d_recorded)
            begin
                store_to_dmem(mem_address, mem_wdata, mem_byte_enable);
                check_write(mem_address, mem_wdata, mem_byte_enable);
                d_recorded = 1'b1;          // level stays high until the pipeline moves
            end

            adv = i_mem_resp && (d_mem_resp || !access);
            d_pending = access && !adv;
            pend_addr = mem_address;
            pend_write = mem_write;
            if (adv)
            begin
                i_fresh = 1'b1;
                d_fresh = 1'b1;
                d_recorded = 1'b0;
            end
        end
        else if (cycle > RESET_CYCLES)
        begin
            $display("instr_read is low after reset was released");
            level_errors++;
        end
    end

    initial
    begin : main
        int i;
        clk = 1'b0;
        rst_n = 1'b0;
        i_mem_resp = 1'b0;
        d_mem_resp = 1'b0;
        instr_rdata = '0;
        mem_rdata = '0;
        seed = 32'hab128369;
        cycle = 0;
        writes_seen = 0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        level_errors = 0;
        i_fresh = 1'b1;
        d_fresh = 1'b1;
        d_recorded = 1'b0;
        d_pending = 1'b0;
        for (i = 0; i < 128; i++)
            patterns[i] = '0;
        for (i = 0; i < 32768; i++)
            dmem[i] = lc3b_pkg::lc3b_word'(i << 1) ^ 16'h5ac3;
        $readmemh("test/cpu_patterns.mem", patterns);
        exp_count = patterns[EXP_BASE];
        loaded = 1'b1;

        wait (writes_seen == exp_count);
        repeat (DRAIN_CYCLES) @(posedge clk);  // the spin loop must not store again

        errors += level_errors;
        if (level_errors == 0)
        begin
            tests_passed++;
            $display("request levels held until response: ok");
        end
        else
        begin
            tests_failed++;
            $display("request levels held until response: failed");
        end
        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        wait (loaded);
        limit = RESET_CYCLES + DRAIN_CYCLES + 40 * exp_count * (MAX_DELAY + 1);
        repeat (limit) @(posedge clk);
        $display("timeout: %0d of %0d expected writes seen after %0d cycles",
                 writes_seen, exp_count, limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lc3b_cpu.f ====
+incdir+source
source/lc3b_pkg.sv
source/fwd_if.sv
source/control_rom.sv
source/regfile.sv
source/hazard_unit.sv
source/datapath.sv
source/lc3b_cpu.sv
test/lc3b_cpu_tb.sv

// ==== test/cpu_patterns.mem ====
// words from @0: program image, word index = byte address / 2
// words from @40: write count, then address, data, byte enable of each expected write
@0
1225 // add  r1, r0, #5        r1 = 0005
1463 // add  r2, r1, #3        r2 = 0008, r1 from memory stage
1681 // add  r3, r2, r1        r3 = 000d, memory and writeback forwards
58c2 // and  r4, r3, r2        r4 = 0008
9b3f // not  r5, r4            r5 = fff7
ec7a // lea  r6, #122          r6 = 0100
7780 // str  r3, r6, #0
7b81 // str  r5, r6, #1
6f81 // ldr  r7, r6, #1        r7 = fff7
13c4 // add  r1, r7, r4        load-use, r1 = ffff
7382 // str  r1, r6, #2
3786 // stb  r3, r6, #6        even byte
3987 // stb  r4, r6, #7        odd byte
0401 // brz  +1                not taken
7584 // str  r2, r6, #4
0801 // brn  +1                taken
7b85 // str  r5, r6, #5        skipped
e002 // lea  r0, #2            r0 = 0028
c000 // jmp  r0
7386 // str  r1, r6, #6        skipped
7187 // str  r0, r6, #7
6583 // ldr  r2, r6, #3        merged bytes, r2 = 080d
7588 // str  r2, r6, #8        load-use on the store source
0fff // brnzp -1               spin here
@40
0008
0100 000d 0003
0102 fff7 0003
0104 ffff 0003
0106 0d0d 0001
0107 0808 0002
0108 0008 0003
010e 0028 0003
0110 080d 0003
